// File: compile.f
verilog/frame_pkg.sv
verilog/meta_pkg.sv
verilog/frame_fifo.sv
verilog/frame_skid.sv
verilog/frame_packer.sv
verilog/packer_top.sv
verification/packer_checker.sv
verification/packer_tb.sv

// File: Makefile
TOP := packer_tb
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@! grep -q "Simulation FAILED" $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: verification/packer_tb.sv
/*
 * packer subsystem testbench
 * random packets and metadata checked against a queue model of the packer rules
 */
`timescale 1ns/1ns

module packer_tb
    import frame_pkg::*;
    import meta_pkg::*;
();

    localparam int FIFO_DEPTH     = 16;
    localparam int SPKT_MIN_WORDS = 24;
    localparam int SPKT_MAX_PKTS  = 4;
    localparam int MAX_PKTS       = 24;
    // packets over all runs below
    localparam int TOTAL_PKTS     = 80;
    localparam int CYCLE_LIMIT    = 40 * TOTAL_PKTS;

    logic        clk;
    logic        rst;
    frame_beat_t frame_in;
    logic        frame_in_valid;
    logic        frame_in_ready;
    pkt_meta_t   meta_in;
    logic        meta_in_valid;
    logic        meta_in_ready;
    frame_beat_t frame_out;
    spkt_info_t  spkt_out;
    logic        frame_out_valid;
    logic        frame_out_ready;

    integer      seed;
    int          err_value = 0;
    int          err_other = 0;
    int          cycle = 0;
    string       test_name;
    logic        gaps;
    // set once a superframe starts inside the running test
    logic        sf_fresh;

    // packet set of the running test
    int          n_pkts;
    int          act_len [MAX_PKTS];
    pkt_meta_t   pkt_meta [MAX_PKTS];
    frame_word_t pkt_base [MAX_PKTS];

    // expected output and the model's open superframe
    frame_beat_t exp_beats [$];
    spkt_info_t  exp_spkt [$];
    pkt_cnt_t    m_idx;
    spkt_len_t   m_words;
    logic        m_discard;

    packer_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .SPKT_MIN_WORDS (SPKT_MIN_WORDS),
        .SPKT_MAX_PKTS  (SPKT_MAX_PKTS)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .frame_in        (frame_in),
        .frame_in_valid  (frame_in_valid),
        .frame_in_ready  (frame_in_ready),
        .meta_in         (meta_in),
        .meta_in_valid   (meta_in_valid),
        .meta_in_ready   (meta_in_ready),
        .frame_out       (frame_out),
        .spkt_out        (spkt_out),
        .frame_out_valid (frame_out_valid),
        .frame_out_ready (frame_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            err_other++;
            $display("timeout after %0d cycles, output beats still missing", cycle);
            $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic make_packets(input int n, input int lo, input int hi, input logic bad);
        for (int p = 0; p < n; p++) begin
            act_len[p]          = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
            pkt_meta[p].len     = pkt_len_t'(act_len[p]);
            pkt_meta[p].channel = channel_t'($random(seed));
            pkt_base[p]         = frame_word_t'($random(seed));
            // roughly one in four announces a wrong length
            if (bad && ($random(seed) % 4 == 0)) begin
                pkt_meta[p].len = pkt_len_t'(act_len[p] + 1 + int'($unsigned($random(seed)) % 3));
            end
        end
        n_pkts = n;
    endtask

    task automatic build_expected();
        frame_beat_t beat;
        pkt_hdr_t    hdr;
        spkt_info_t  summary;
        spkt_len_t   words;
        pkt_cnt_t    cnt;
        logic        closes;
        logic        discard;
        for (int p = 0; p < n_pkts; p++) begin
            hdr         = '0;
            hdr.len     = pkt_meta[p].len;
            hdr.channel = pkt_meta[p].channel;
            hdr.pkt_idx = m_idx;
            beat        = '{data: hdr, sof: (m_idx == '0), eof: 1'b0};
            exp_beats.push_back(beat);
            // headers do not count toward the word total
            words   = m_words + spkt_len_t'(act_len[p]);
            cnt     = m_idx + 1'b1;
            closes  = (words >= spkt_len_t'(SPKT_MIN_WORDS))
                   || (cnt == pkt_cnt_t'(SPKT_MAX_PKTS));
            discard = m_discard || (pkt_meta[p].len != pkt_len_t'(act_len[p]));
            for (int i = 0; i < act_len[p]; i++) begin
                beat = '{data: pkt_base[p] + i, sof: 1'b0, eof: closes && (i == act_len[p] - 1)};
                exp_beats.push_back(beat);
            end
            if (closes) begin
                summary = '{total_len: words + spkt_len_t'(cnt), pkt_cnt: cnt,
                            discard: discard};
                exp_spkt.push_back(summary);
                m_idx     = '0;
                m_words   = '0;
                m_discard = 1'b0;
            end else begin
                m_idx     = cnt;
                m_words   = words;
                m_discard = discard;
            end
        end
    endtask

    task automatic send_frames();
        for (int p = 0; p < n_pkts; p++) begin
            for (int i = 0; i < act_len[p]; i++) begin
                @(posedge clk);
                if (gaps && ($random(seed) % 3 == 0)) begin
                    frame_in_valid <= 1'b0;
                    @(posedge clk);
                end
                frame_in       <= '{data: pkt_base[p] + i, sof: (i == 0),
                                    eof: (i == act_len[p] - 1)};
                frame_in_valid <= 1'b1;
                @(negedge clk);
                while (!frame_in_ready) begin
                    @(negedge clk);
                end
            end
        end
        @(posedge clk);
        frame_in_valid <= 1'b0;
    endtask

    task automatic send_meta();
        for (int p = 0; p < n_pkts; p++) begin
            @(posedge clk);
            if (gaps && ($random(seed) % 2 == 0)) begin
                meta_in_valid <= 1'b0;
                @(posedge clk);
            end
            meta_in       <= pkt_meta[p];
            meta_in_valid <= 1'b1;
            @(negedge clk);
            while (!meta_in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        meta_in_valid <= 1'b0;
    endtask

    task automatic collect_output();
        frame_beat_t exp_b;
        spkt_info_t  exp_s;
        while (exp_beats.size() > 0) begin
            @(posedge clk);
            frame_out_ready <= gaps ? ($random(seed) % 4 != 0) : 1'b1;
            // a beat seen here transfers on the next rising edge
            @(negedge clk);
            if (frame_out_valid && frame_out_ready) begin
                exp_b = exp_beats.pop_front();
                if (exp_b.sof) begin
                    sf_fresh = 1'b1;
                end
                assert (frame_out === exp_b) else begin
                    err_value++;
                    $display("ERR %s beat: expected %h actual %h", test_name, exp_b, frame_out);
                end
                if (exp_b.eof) begin
                    exp_s = exp_spkt.pop_front();
                    assert (spkt_out === exp_s) else begin
                        err_value++;
                        $display("ERR %s summary: expected %h actual %h", test_name, exp_s,
                                 spkt_out);
                    end
                    if (sf_fresh && test_name == "close_len") begin
                        assert (spkt_out.pkt_cnt <= 4'd3) else begin
                            err_value++;
                            $display("ERR %s pkt_cnt: expected <= 3 actual %0d", test_name,
                                     spkt_out.pkt_cnt);
                        end
                    end
                    if (sf_fresh && test_name == "close_cnt") begin
                        assert (spkt_out.pkt_cnt == 4'd4) else begin
                            err_value++;
                            $display("ERR %s pkt_cnt: expected 4 actual %0d", test_name,
                                     spkt_out.pkt_cnt);
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_packets(input string name, input logic with_gaps);
        test_name = name;
        gaps      = with_gaps;
        sf_fresh  = 1'b0;
        build_expected();
        fork
            send_frames();
            send_meta();
            collect_output();
        join
    endtask

    initial begin
        seed            = 32'h2b5e_5e5e;
        rst             = 1'b1;
        frame_in        = '0;
        frame_in_valid  = 1'b0;
        meta_in         = '0;
        meta_in_valid   = 1'b0;
        frame_out_ready = 1'b0;
        gaps            = 1'b0;
        sf_fresh        = 1'b0;
        m_idx           = '0;
        m_words         = '0;
        m_discard       = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // empty FIFO takes input, no output beat yet
        @(negedge clk);
        assert (frame_in_ready === 1'b1 && frame_out_valid === 1'b0) else begin
            err_value++;
            $display("ERR reset: expected ready 1 valid 0 actual ready %b valid %b",
                     frame_in_ready, frame_out_valid);
        end

        make_packets(12, 1, 12, 1'b0);
        run_packets("headers", 1'b0);
        // long packets, closed by the word total
        make_packets(12, 10, 12, 1'b0);
        run_packets("close_len", 1'b0);
        make_packets(16, 1, 3, 1'b0);
        run_packets("close_cnt", 1'b0);
        // wrong meta lengths mark their superframes
        make_packets(16, 1, 12, 1'b1);
        run_packets("summary", 1'b0);
        // model output has no timing, so stalls must not change it
        make_packets(24, 1, 12, 1'b1);
        run_packets("backpressure", 1'b1);

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verification/packer_checker.sv
/*
 * handshake and framing assertions for the packer subsystem
 */
`timescale 1ns/1ns

module packer_checker
    import frame_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input frame_beat_t frame_in,
    input logic        frame_in_valid,
    input logic        frame_in_ready,
    input frame_beat_t frame_out,
    input logic        frame_out_valid,
    input logic        frame_out_ready
);

    // superframe started, eof not yet transferred
    logic sf_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            sf_open <= 1'b0;
        end else if (frame_out_valid && frame_out_ready) begin
            if (frame_out.eof) begin
                sf_open <= 1'b0;
            end else if (frame_out.sof) begin
                sf_open <= 1'b1;
            end
        end
    end

    in_hold: assert property (@(posedge clk) disable iff (rst)
        frame_in_valid && !frame_in_ready |=> frame_in_valid && $stable(frame_in))
        else $error("frame_in dropped valid or changed data before ready");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        frame_out_valid && !frame_out_ready |=> frame_out_valid && $stable(frame_out))
        else $error("frame_out dropped valid or changed data before ready");

    quiet_after_reset: assert property (@(posedge clk) rst |=> !frame_out_valid)
        else $error("frame_out valid in the cycle after reset");

    single_sof: assert property (@(posedge clk) disable iff (rst)
        frame_out_valid && frame_out.sof |-> !sf_open)
        else $error("sof on frame_out inside an open superframe");

endmodule

bind packer_top packer_checker i_checker (
    .clk             (clk),
    .rst             (rst),
    .frame_in        (frame_in),
    .frame_in_valid  (frame_in_valid),
    .frame_in_ready  (frame_in_ready),
    .frame_out       (frame_out),
    .frame_out_valid (frame_out_valid),
    .frame_out_ready (frame_out_ready)
);

// File: verilog/packer_top.sv
/*
 * packer subsystem top level
 * frame input through FIFO and skid register into the packer,
 * metadata straight to the packer
 */
`timescale 1ns/1ns

module packer_top
    import frame_pkg::*;
    import meta_pkg::*;
#(
    parameter int FIFO_DEPTH     = 16,
    parameter int SPKT_MIN_WORDS = 24,
    parameter int SPKT_MAX_PKTS  = 4
) (
    input  logic        clk,
    input  logic        rst,

    input  frame_beat_t frame_in,
    input  logic        frame_in_valid,
    output logic        frame_in_ready,

    input  pkt_meta_t   meta_in,
    input  logic        meta_in_valid,
    output logic        meta_in_ready,

    output frame_beat_t frame_out,
    output spkt_info_t  spkt_out,
    output logic        frame_out_valid,
    input  logic        frame_out_ready
);

    // FIFO to skid
    frame_beat_t buffer_beat;
    logic        buffer_valid;
    logic        buffer_ready;

    // skid to packer
    frame_beat_t pipe_beat;
    logic        pipe_valid;
    logic        pipe_ready;

    frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (frame_in),
        .in_valid  (frame_in_valid),
        .in_ready  (frame_in_ready),
        .out_beat  (buffer_beat),
        .out_valid (buffer_valid),
        .out_ready (buffer_ready)
    );

    frame_skid skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (buffer_beat),
        .in_valid  (buffer_valid),
        .in_ready  (buffer_ready),
        .out_beat  (pipe_beat),
        .out_valid (pipe_valid),
        .out_ready (pipe_ready)
    );

    frame_packer #(
        .SPKT_MIN_WORDS (SPKT_MIN_WORDS),
        .SPKT_MAX_PKTS  (SPKT_MAX_PKTS)
    ) packer_i (
        .clk        (clk),
        .rst        (rst),
        .in_beat    (pipe_beat),
        .in_valid   (pipe_valid),
        .in_ready   (pipe_ready),
        .meta       (meta_in),
        .meta_valid (meta_in_valid),
        .meta_ready (meta_in_ready),
        .out_beat   (frame_out),
        .out_spkt   (spkt_out),
        .out_valid  (frame_out_valid),
        .out_ready  (frame_out_ready)
    );

endmodule

// File: verilog/frame_packer.sv
/*
 * frame packer
 * puts a header word in front of each packet, joins packets into
 * superframes and reports a summary with the last superframe word
 */
`timescale 1ns/1ns

module frame_packer
    import frame_pkg::*;
    import meta_pkg::*;
#(
    parameter int SPKT_MIN_WORDS = 24,
    parameter int SPKT_MAX_PKTS  = 4
) (
    input  logic        clk,
    input  logic        rst,

    input  frame_beat_t in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    input  pkt_meta_t   meta,
    input  logic        meta_valid,
    output logic        meta_ready,

    output frame_beat_t out_beat,
    output spkt_info_t  out_spkt,
    output logic        out_valid,
    input  logic        out_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_data
    } state_t;

    state_t    state;
    pkt_meta_t cur_meta;
    // index of the current packet in its superframe
    pkt_cnt_t  pkt_idx;
    // data words already passed of the current packet
    pkt_len_t  word_cnt;
    // data words of the finished packets in the open superframe
    spkt_len_t spkt_words;
    logic      discard;

    pkt_hdr_t  hdr;
    pkt_len_t  pkt_words;
    spkt_len_t data_total;
    pkt_cnt_t  pkt_num;
    logic      len_bad;
    logic      spkt_close;
    logic      in_xfer;
    logic      last_xfer;
    logic      meta_accept;

    // figures as they stand with the current data beat included
    assign pkt_words  = word_cnt + 1'b1;
    assign data_total = spkt_words + spkt_len_t'(pkt_words);
    assign pkt_num    = pkt_idx + 1'b1;
    assign len_bad    = (pkt_words != cur_meta.len);

    // closing rule, checked on each packet's last word
    assign spkt_close = (data_total >= spkt_len_t'(SPKT_MIN_WORDS))
                     || (pkt_num == pkt_cnt_t'(SPKT_MAX_PKTS));

    assign in_xfer   = in_valid && in_ready;
    assign last_xfer = in_xfer && in_beat.eof;

    // next meta may be taken together with the last word of a packet,
    // so the header is the only extra cycle
    assign meta_ready  = (state == st_idle) || last_xfer;
    assign meta_accept = meta_valid && meta_ready;

    always_comb begin
        hdr          = '0;
        hdr.len      = cur_meta.len;
        hdr.channel  = cur_meta.channel;
        hdr.mismatch = 1'b0;
        hdr.pkt_idx  = pkt_idx;
    end

    always_comb begin
        out_beat  = '0;
        out_valid = 1'b0;
        in_ready  = 1'b0;
        case (state)
            st_header: begin
                out_valid     = 1'b1;
                out_beat.data = hdr;
                // first header opens the superframe
                out_beat.sof  = (pkt_idx == '0);
            end
            st_data: begin
                out_valid     = in_valid;
                in_ready      = out_ready;
                out_beat.data = in_beat.data;
                out_beat.eof  = in_beat.eof && spkt_close;
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

    // only looked at on the eof beat
    assign out_spkt.total_len = data_total + spkt_len_t'(pkt_num);
    assign out_spkt.pkt_cnt   = pkt_num;
    assign out_spkt.discard   = discard || len_bad;

    always_ff @(posedge clk) begin
        if (meta_accept) begin
            cur_meta <= meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            pkt_idx    <= '0;
            word_cnt   <= '0;
            spkt_words <= '0;
            discard    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (meta_accept) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (out_ready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (last_xfer) begin
                        state    <= meta_accept ? st_header : st_idle;
                        word_cnt <= '0;
                        if (spkt_close) begin
                            pkt_idx    <= '0;
                            spkt_words <= '0;
                            discard    <= 1'b0;
                        end else begin
                            pkt_idx    <= pkt_num;
                            spkt_words <= data_total;
                            discard    <= discard || len_bad;
                        end
                    end else if (in_xfer) begin
                        word_cnt <= pkt_words;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/frame_skid.sv
/*
 * two-entry skid register between FIFO and packer
 * registered in_ready at full throughput
 */
`timescale 1ns/1ns

module frame_skid
    import frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  frame_beat_t in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    output frame_beat_t out_beat,
    output logic        out_valid,
    input  logic        out_ready
);

    frame_beat_t main_beat;
    frame_beat_t spare_beat;
    logic        main_valid;
    logic        spare_valid;
    logic        main_load;
    logic        in_xfer;

    // ready straight from a flop
    assign in_ready  = !spare_valid;
    assign out_valid = main_valid;
    assign out_beat  = main_beat;

    // main register empty or being drained this cycle
    assign main_load = out_ready || !main_valid;
    assign in_xfer   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_load) begin
            if (spare_valid) begin
                main_valid  <= 1'b1;
                spare_valid <= 1'b0;
            end else begin
                main_valid <= in_valid;
            end
        end else if (in_xfer) begin
            // output stalled, park the beat
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_beat <= spare_valid ? spare_beat : in_beat;
        end
        if (!main_load && in_xfer) begin
            spare_beat <= in_beat;
        end
    end

endmodule

// File: verilog/frame_fifo.sv
/*
 * synchronous FIFO for frame beats
 * valid/ready on both sides, a written beat is readable the next cycle
 */
`timescale 1ns/1ns

module frame_fifo
    import frame_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst,

    input  frame_beat_t in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    output frame_beat_t out_beat,
    output logic        out_valid,
    input  logic        out_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    frame_beat_t mem [FIFO_DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        count;
    logic        do_wr;
    logic        do_rd;

    // pointer step with wrap for any depth
    function automatic ptr_t ptr_next(input ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(FIFO_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign in_ready  = (count != cnt_t'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // occupancy only moves when one side transfers alone
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/meta_pkg.sv
/*
 * packet metadata types
 * input meta items, the inserted header word and the superframe summary
 */
package meta_pkg;

    // packet length in words
    typedef logic [11:0] pkt_len_t;
    typedef logic [3:0]  channel_t;
    // packet count or index inside a superframe
    typedef logic [3:0]  pkt_cnt_t;
    // superframe length in words
    typedef logic [15:0] spkt_len_t;

    // one item of the metadata stream
    typedef struct packed {
        pkt_len_t len;
        channel_t channel;
    } pkt_meta_t;

    // header word put in front of each packet, 32 bits
    typedef struct packed {
        logic [10:0] pad;
        pkt_cnt_t    pkt_idx;
        logic        mismatch;
        channel_t    channel;
        pkt_len_t    len;
    } pkt_hdr_t;

    // summary sent with the last word of a superframe
    typedef struct packed {
        spkt_len_t total_len;
        pkt_cnt_t  pkt_cnt;
        logic      discard;
    } spkt_info_t;

endpackage

// File: verilog/frame_pkg.sv
/*
 * frame bus types
 * one data word and the beat that carries it with its framing flags
 */
package frame_pkg;

    // width of one frame bus word
    localparam int FRAME_WORD_W = 32;

    // one data word of the frame bus
    typedef logic [FRAME_WORD_W-1:0] frame_word_t;

    // one bus beat, word plus start/end of frame marks
    typedef struct packed {
        frame_word_t data;
        logic        sof;
        logic        eof;
    } frame_beat_t;

endpackage
